//--- flist.f
hdl/mem_pkg.sv
hdl/irq_pkg.sv
hdl/irq_id_enc.sv
hdl/lsu_demux.sv
hdl/ram_mux.sv
hdl/data_ram.sv
hdl/core_region.sv
dv/core_region_sva.sv
dv/tb_core_region.sv

//--- run.sh
#!/bin/sh
# Build and run the core_region testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_core_region \
  -o sim_tb_core_region
status=$?
if [ $status -ne 0 ]; then
  echo "compile step returned $status"
  exit 1
fi

./obj_dir/sim_tb_core_region > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned $status"
  exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/tb_core_region.sv
`timescale 1ns/100ps

module tb_core_region;

  import mem_pkg::*;
  import irq_pkg::*;

  localparam int NUM_WORDS = 16;
  localparam int NUM_LOCAL = 60;
  localparam int NUM_MIXED = 60;
  localparam int NUM_DMA   = 60;
  localparam int NUM_IRQ   = 40;
  localparam int NUM_TXN   = NUM_WORDS + NUM_LOCAL + NUM_MIXED + NUM_DMA + NUM_IRQ + 20;

  logic                      clk;
  logic                      rst_n;
  logic [IRQ_LINES-1:0]      irq_i;
  logic                      irq_pending_o;
  logic [IRQ_ID_WIDTH-1:0]   irq_id_o;
  logic                      lsu_req_i;
  logic [ADDR_WIDTH-1:0]     lsu_addr_i;
  logic                      lsu_we_i;
  logic [BE_WIDTH-1:0]       lsu_be_i;
  logic [DATA_WIDTH-1:0]     lsu_wdata_i;
  logic                      lsu_gnt_o;
  logic                      lsu_rvalid_o;
  logic [DATA_WIDTH-1:0]     lsu_rdata_o;
  logic                      dma_req_i;
  logic [RAM_ADDR_WIDTH-1:0] dma_addr_i;
  logic                      dma_we_i;
  logic [BE_WIDTH-1:0]       dma_be_i;
  logic [DATA_WIDTH-1:0]     dma_wdata_i;
  logic [DATA_WIDTH-1:0]     dma_rdata_o;
  logic                      ext_req_o;
  logic [ADDR_WIDTH-1:0]     ext_addr_o;
  logic                      ext_we_o;
  logic [BE_WIDTH-1:0]       ext_be_o;
  logic [DATA_WIDTH-1:0]     ext_wdata_o;
  logic                      ext_gnt_i;
  logic                      ext_rvalid_i;
  logic [DATA_WIDTH-1:0]     ext_rdata_i;

  // stimulus and responder generators
  logic [31:0] drv_lfsr;
  logic [31:0] rsp_lfsr;
  logic        dma_mode;

  // reference model state
  logic [DATA_WIDTH-1:0] model [NUM_WORDS];
  logic                  rsp_pending;
  logic                  rsp_read;
  logic [DATA_WIDTH-1:0] rsp_exp;
  logic                  dma_rd_pending;
  logic [DATA_WIDTH-1:0] dma_exp;

  // external bus responder state
  logic                  hit_q;
  logic [ADDR_WIDTH-1:0] hit_addr;

  core_region dut_i (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 32'h80200003;
    end
    return s;
  endfunction

  // one LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      drv_lfsr = lfsr_step(drv_lfsr);
      r = {r[30:0], drv_lfsr[0]};
    end
    return r;
  endfunction

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("Error: %s actual %h expected %h", name, act, exp);
      fail_run();
    end
  endtask

  function automatic logic is_local_addr(input logic [ADDR_WIDTH-1:0] a);
    return a[REGION_TAG_MSB:REGION_TAG_LSB] == LOCAL_REGION_TAG;
  endfunction

  // system bus stimulus, random only in the arbitration phase
  task automatic drive_dma();
    if (dma_mode) begin
      dma_req_i   = 1'(rand_bits(1));
      dma_we_i    = 1'(rand_bits(1));
      dma_be_i    = BE_WIDTH'(rand_bits(BE_WIDTH));
      dma_wdata_i = rand_bits(32);
      dma_addr_i  = RAM_ADDR_WIDTH'(rand_bits(4));
    end else begin
      dma_req_i = 1'b0;
    end
  endtask

  // called on a falling edge, returns on the falling edge after the grant
  task automatic lsu_access(input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    drive_dma();
    forever begin
      @(posedge clk);
      if (lsu_gnt_o) begin
        break;
      end
      @(negedge clk);
      drive_dma();
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    dma_req_i = 1'b0;
  endtask

  task automatic dma_write(input logic [9:0] idx, input logic [31:0] data);
    dma_req_i   = 1'b1;
    dma_addr_i  = idx;
    dma_we_i    = 1'b1;
    dma_be_i    = 4'hf;
    dma_wdata_i = data;
    @(negedge clk);
    dma_req_i = 1'b0;
  endtask

  function automatic logic [31:0] local_addr(input logic [3:0] idx);
    return {LOCAL_REGION_TAG, 20'h0} | {26'h0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] ext_addr();
    logic [31:0] a;
    a = rand_bits(32);
    if (is_local_addr(a)) begin
      a[31] = ~a[31];
    end
    return a;
  endfunction

  // random load or store to one of the two targets
  task automatic random_access(input logic to_ext);
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    if (to_ext) begin
      addr = ext_addr();
    end else begin
      addr = local_addr(4'(rand_bits(4)));
    end
    we    = 1'(rand_bits(1));
    be    = 4'(rand_bits(4));
    wdata = rand_bits(32);
    lsu_access(addr, we, be, wdata);
  endtask

  // responder answers one cycle after each grant
  always @(posedge clk) begin
    hit_q    <= ext_req_o & ext_gnt_i;
    hit_addr <= ext_addr_o;
  end

  always @(negedge clk) begin
    ext_rvalid_i = hit_q;
    ext_rdata_i  = hit_q ? (hit_addr ^ 32'ha5a5a5a5) : '0;
    rsp_lfsr     = lfsr_step(rsp_lfsr);
    ext_gnt_i    = rsp_lfsr[0];
  end

  // monitor samples settled values at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      check("lsu_rvalid_o", 32'(lsu_rvalid_o), 32'(rsp_pending));
      if (rsp_pending && rsp_read) begin
        check("lsu_rdata_o", lsu_rdata_o, rsp_exp);
      end
      if (dma_rd_pending) begin
        check("dma_rdata_o", dma_rdata_o, dma_exp);
      end
      rsp_pending    = 1'b0;
      dma_rd_pending = 1'b0;
      if (dma_req_i) begin
        if (dma_we_i) begin
          for (int b = 0; b < BE_WIDTH; b++) begin
            if (dma_be_i[b]) begin
              model[dma_addr_i[3:0]][b*8 +: 8] = dma_wdata_i[b*8 +: 8];
            end
          end
        end else begin
          dma_exp        = model[dma_addr_i[3:0]];
          dma_rd_pending = 1'b1;
        end
      end
      if (lsu_req_i) begin
        check("ext_req_o", 32'(ext_req_o), 32'(!is_local_addr(lsu_addr_i)));
        if (!is_local_addr(lsu_addr_i)) begin
          check("ext_addr_o", ext_addr_o, lsu_addr_i);
          check("ext_we_o", 32'(ext_we_o), 32'(lsu_we_i));
          check("ext_be_o", 32'(ext_be_o), 32'(lsu_be_i));
          check("ext_wdata_o", ext_wdata_o, lsu_wdata_i);
        end
      end else begin
        check("ext_req_o", 32'(ext_req_o), 32'h0);
      end
      if (lsu_gnt_o) begin
        if (!lsu_req_i) begin
          $display("grant seen without a load/store request");
          fail_run();
        end
        rsp_pending = 1'b1;
        rsp_read    = !lsu_we_i;
        if (is_local_addr(lsu_addr_i)) begin
          if (dma_req_i) begin
            $display("core was granted the RAM during a system bus access");
            fail_run();
          end
          if (lsu_we_i) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
              if (lsu_be_i[b]) begin
                model[lsu_addr_i[5:2]][b*8 +: 8] = lsu_wdata_i[b*8 +: 8];
              end
            end
          end else begin
            rsp_exp = model[lsu_addr_i[5:2]];
          end
        end else begin
          rsp_exp = lsu_addr_i ^ 32'ha5a5a5a5;
        end
      end
    end
  end

  initial begin
    #(NUM_TXN * 20 * 20);
    $display("timeout: the transactions did not complete in the expected time");
    fail_run();
  end

  initial begin
    logic [31:0] v;
    logic [31:0] t;
    logic [4:0]  exp_id;
    clk = 1'b0;
    rst_n = 1'b0;
    irq_i = '0;
    lsu_req_i = 1'b0;
    lsu_addr_i = '0;
    lsu_we_i = 1'b0;
    lsu_be_i = '0;
    lsu_wdata_i = '0;
    dma_req_i = 1'b0;
    dma_addr_i = '0;
    dma_we_i = 1'b0;
    dma_be_i = '0;
    dma_wdata_i = '0;
    ext_gnt_i = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i = '0;
    drv_lfsr = 32'h182a;
    rsp_lfsr = 32'h182a;
    dma_mode = 1'b0;
    rsp_pending = 1'b0;
    rsp_read = 1'b0;
    dma_rd_pending = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    repeat (4) begin
      @(posedge clk);
      check("lsu_rvalid_o", 32'(lsu_rvalid_o), 32'h0);
      check("ext_req_o", 32'(ext_req_o), 32'h0);
    end
    @(negedge clk);

    // fill pattern through the system bus port
    for (int i = 0; i < NUM_WORDS; i++) begin
      dma_write(i[9:0], 32'h3c5a0000 ^ (i * 32'h01030507));
    end

    for (int i = 0; i < NUM_LOCAL; i++) begin
      random_access(1'b0);
    end

    // both targets back to back
    for (int i = 0; i < NUM_MIXED; i++) begin
      random_access(1'(rand_bits(1)));
    end

    dma_mode = 1'b1;
    for (int i = 0; i < NUM_DMA; i++) begin
      random_access(1'b0);
    end
    dma_mode = 1'b0;
    repeat (3) @(negedge clk);

    for (int i = 0; i < NUM_IRQ; i++) begin
      v = (i == 0) ? 32'h0 : rand_bits(32) >> rand_bits(5);
      irq_i = v;
      // top set bit position, counted by halving
      exp_id = '0;
      t = v >> 1;
      while (t != 0) begin
        exp_id++;
        t = t >> 1;
      end
      @(posedge clk);
      check("irq_pending_o", 32'(irq_pending_o), 32'(v != 0));
      check("irq_id_o", 32'(irq_id_o), 32'(exp_id));
      @(negedge clk);
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- dv/core_region_sva.sv
`timescale 1ns/100ps

module core_region_sva (
  input logic                           clk,
  input logic                           rst_n,
  input logic [mem_pkg::ADDR_WIDTH-1:0] lsu_addr_i,
  input logic                           lsu_gnt_o,
  input logic                           ext_req_o,
  input logic                           dma_req_i,
  input logic                           ram_rvalid
);

  import mem_pkg::*;

  logic local_addr;

  assign local_addr = (lsu_addr_i[REGION_TAG_MSB:REGION_TAG_LSB] == LOCAL_REGION_TAG);

  // RAM answers the core one cycle after a local grant
  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_gnt_o && local_addr) |=> ram_rvalid)
    else $error("core rvalid missing after local grant");

  no_ext_for_local: assert property (@(posedge clk) disable iff (!rst_n)
    !(ext_req_o && local_addr))
    else $error("external request for a local address");

  // system bus has priority on the RAM
  no_core_gnt_under_dma: assert property (@(posedge clk) disable iff (!rst_n)
    !(lsu_gnt_o && local_addr && dma_req_i))
    else $error("core granted while the system bus owns the RAM");

endmodule

bind core_region core_region_sva sva_i (.*);

//--- hdl/core_region.sv
`timescale 1ns/100ps

module core_region (
  input  logic                               clk,
  input  logic                               rst_n,
  // interrupts
  input  logic [irq_pkg::IRQ_LINES-1:0]      irq_i,
  output logic                               irq_pending_o,
  output logic [irq_pkg::IRQ_ID_WIDTH-1:0]   irq_id_o,
  // load/store unit
  input  logic                               lsu_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0]     lsu_addr_i,
  input  logic                               lsu_we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       lsu_be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     lsu_wdata_i,
  output logic                               lsu_gnt_o,
  output logic                               lsu_rvalid_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     lsu_rdata_o,
  // system bus master
  input  logic                               dma_req_i,
  input  logic [mem_pkg::RAM_ADDR_WIDTH-1:0] dma_addr_i,
  input  logic                               dma_we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       dma_be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     dma_wdata_i,
  output logic [mem_pkg::DATA_WIDTH-1:0]     dma_rdata_o,
  // external bus
  output logic                               ext_req_o,
  output logic [mem_pkg::ADDR_WIDTH-1:0]     ext_addr_o,
  output logic                               ext_we_o,
  output logic [mem_pkg::BE_WIDTH-1:0]       ext_be_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     ext_wdata_o,
  input  logic                               ext_gnt_i,
  input  logic                               ext_rvalid_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     ext_rdata_i
);

  import mem_pkg::*;

  // demux to RAM arbiter
  logic                      ram_req;
  logic [RAM_ADDR_WIDTH-1:0] ram_addr;
  logic                      ram_we;
  logic [BE_WIDTH-1:0]       ram_be;
  logic [DATA_WIDTH-1:0]     ram_wdata;
  logic                      ram_gnt;
  logic                      ram_rvalid;
  logic [DATA_WIDTH-1:0]     ram_rdata;

  // arbiter to RAM
  logic                      mem_en;
  logic [RAM_ADDR_WIDTH-1:0] mem_addr;
  logic                      mem_we;
  logic [BE_WIDTH-1:0]       mem_be;
  logic [DATA_WIDTH-1:0]     mem_wdata;
  logic [DATA_WIDTH-1:0]     mem_rdata;

  irq_id_enc irq_enc_i (
    .irq_i         (irq_i),
    .irq_pending_o (irq_pending_o),
    .irq_id_o      (irq_id_o)
  );

  lsu_demux lsu_demux_i (
    .clk, .rst_n,
    .lsu_req_i, .lsu_addr_i, .lsu_we_i, .lsu_be_i, .lsu_wdata_i,
    .lsu_gnt_o, .lsu_rvalid_o, .lsu_rdata_o,
    .ram_req_o    (ram_req),
    .ram_addr_o   (ram_addr),
    .ram_we_o     (ram_we),
    .ram_be_o     (ram_be),
    .ram_wdata_o  (ram_wdata),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .ext_req_o, .ext_addr_o, .ext_we_o, .ext_be_o, .ext_wdata_o,
    .ext_gnt_i, .ext_rvalid_i, .ext_rdata_i
  );

  ram_mux ram_mux_i (
    .clk, .rst_n,
    .dma_req_i, .dma_addr_i, .dma_we_i, .dma_be_i, .dma_wdata_i, .dma_rdata_o,
    .core_req_i    (ram_req),
    .core_addr_i   (ram_addr),
    .core_we_i     (ram_we),
    .core_be_i     (ram_be),
    .core_wdata_i  (ram_wdata),
    .core_gnt_o    (ram_gnt),
    .core_rvalid_o (ram_rvalid),
    .core_rdata_o  (ram_rdata),
    .mem_en_o      (mem_en),
    .mem_addr_o    (mem_addr),
    .mem_we_o      (mem_we),
    .mem_be_o      (mem_be),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata)
  );

  data_ram data_ram_i (
    .clk     (clk),
    .en_i    (mem_en),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

//--- hdl/data_ram.sv
`timescale 1ns/100ps

module data_ram (
  input  logic                               clk,
  input  logic                               en_i,
  input  logic [mem_pkg::RAM_ADDR_WIDTH-1:0] addr_i,
  input  logic                               we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     wdata_i,
  output logic [mem_pkg::DATA_WIDTH-1:0]     rdata_o
);

  import mem_pkg::*;

  // word storage
  logic [DATA_WIDTH-1:0] mem [DATA_RAM_BYTES/BE_WIDTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // only the enabled byte lanes change
        for (int b = 0; b < BE_WIDTH; b++) begin
          if (be_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- hdl/ram_mux.sv
`timescale 1ns/100ps

module ram_mux (
  input  logic                               clk,
  input  logic                               rst_n,
  // system bus port, always served
  input  logic                               dma_req_i,
  input  logic [mem_pkg::RAM_ADDR_WIDTH-1:0] dma_addr_i,
  input  logic                               dma_we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       dma_be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     dma_wdata_i,
  output logic [mem_pkg::DATA_WIDTH-1:0]     dma_rdata_o,
  // core port
  input  logic                               core_req_i,
  input  logic [mem_pkg::RAM_ADDR_WIDTH-1:0] core_addr_i,
  input  logic                               core_we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       core_be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     core_wdata_i,
  output logic                               core_gnt_o,
  output logic                               core_rvalid_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     core_rdata_o,
  // RAM port
  output logic                               mem_en_o,
  output logic [mem_pkg::RAM_ADDR_WIDTH-1:0] mem_addr_o,
  output logic                               mem_we_o,
  output logic [mem_pkg::BE_WIDTH-1:0]       mem_be_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     mem_wdata_o,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     mem_rdata_i
);

  import mem_pkg::*;

  // core only gets the RAM in idle system bus cycles
  assign core_gnt_o = core_req_i & ~dma_req_i;
  assign mem_en_o   = dma_req_i | core_req_i;

  assign mem_addr_o  = dma_req_i ? dma_addr_i  : core_addr_i;
  assign mem_we_o    = dma_req_i ? dma_we_i    : core_we_i;
  assign mem_be_o    = dma_req_i ? dma_be_i    : core_be_i;
  assign mem_wdata_o = dma_req_i ? dma_wdata_i : core_wdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_o <= 1'b0;
    end else begin
      core_rvalid_o <= core_gnt_o;
    end
  end

  // registered RAM data, each port samples it when it owns the slot
  assign dma_rdata_o  = mem_rdata_i;
  assign core_rdata_o = mem_rdata_i;

endmodule

//--- hdl/lsu_demux.sv
`timescale 1ns/100ps

module lsu_demux (
  input  logic                               clk,
  input  logic                               rst_n,
  // load/store unit
  input  logic                               lsu_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0]     lsu_addr_i,
  input  logic                               lsu_we_i,
  input  logic [mem_pkg::BE_WIDTH-1:0]       lsu_be_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     lsu_wdata_i,
  output logic                               lsu_gnt_o,
  output logic                               lsu_rvalid_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     lsu_rdata_o,
  // local RAM side
  output logic                               ram_req_o,
  output logic [mem_pkg::RAM_ADDR_WIDTH-1:0] ram_addr_o,
  output logic                               ram_we_o,
  output logic [mem_pkg::BE_WIDTH-1:0]       ram_be_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     ram_wdata_o,
  input  logic                               ram_gnt_i,
  input  logic                               ram_rvalid_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     ram_rdata_i,
  // external bus side
  output logic                               ext_req_o,
  output logic [mem_pkg::ADDR_WIDTH-1:0]     ext_addr_o,
  output logic                               ext_we_o,
  output logic [mem_pkg::BE_WIDTH-1:0]       ext_be_o,
  output logic [mem_pkg::DATA_WIDTH-1:0]     ext_wdata_o,
  input  logic                               ext_gnt_i,
  input  logic                               ext_rvalid_i,
  input  logic [mem_pkg::DATA_WIDTH-1:0]     ext_rdata_i
);

  import mem_pkg::*;

  logic        is_local;
  lsu_target_e target_q;

  assign is_local  = (lsu_addr_i[REGION_TAG_MSB:REGION_TAG_LSB] == LOCAL_REGION_TAG);
  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // drop the byte offset for the RAM word address
  assign ram_addr_o  = lsu_addr_i[RAM_ADDR_WIDTH+1:2];
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = (ram_req_o & ram_gnt_i) | (ext_req_o & ext_gnt_i);

  // both sides answer one cycle after grant, so the last grant owns the response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      target_q <= TARGET_RAM;
    end else if (lsu_gnt_o) begin
      target_q <= is_local ? TARGET_RAM : TARGET_EXT;
    end
  end

  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (target_q == TARGET_EXT) ? ext_rdata_i : ram_rdata_i;

endmodule

//--- hdl/irq_id_enc.sv
`timescale 1ns/100ps

module irq_id_enc (
  input  logic [irq_pkg::IRQ_LINES-1:0]    irq_i,
  output logic                             irq_pending_o,
  output logic [irq_pkg::IRQ_ID_WIDTH-1:0] irq_id_o
);

  import irq_pkg::*;

  assign irq_pending_o = |irq_i;

  // highest set line wins, zero when idle
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < IRQ_LINES; i++) begin
      if (irq_i[i]) begin
        irq_id_o = i[IRQ_ID_WIDTH-1:0];
      end
    end
  end

endmodule

//--- hdl/irq_pkg.sv
package irq_pkg;

  // interrupt lines into the core
  localparam int IRQ_LINES = 32;

  // id of the selected line
  localparam int IRQ_ID_WIDTH = $clog2(IRQ_LINES);

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

  // data word and byte lanes
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH   = DATA_WIDTH / 8;

  // core byte address
  localparam int ADDR_WIDTH = 32;

  // local data RAM, 1k words
  localparam int DATA_RAM_BYTES = 4096;
  localparam int RAM_ADDR_WIDTH = 10;

  // region tag in the upper address bits
  localparam int REGION_TAG_MSB = 31;
  localparam int REGION_TAG_LSB = 20;

  // tag that selects the local RAM, all others go to the external bus
  localparam logic [REGION_TAG_MSB-REGION_TAG_LSB:0] LOCAL_REGION_TAG = 12'h001;

  // side that owes the next load/store response
  typedef enum logic {
    TARGET_RAM = 1'b0,
    TARGET_EXT = 1'b1
  } lsu_target_e;

endpackage
